// File: verilog.f
+incdir+source
source/fp_alu_pkg.sv
source/fp_logic_unit.sv
source/fp_compare_unit.sv
source/fp_saturator.sv
source/result_delay_line.sv
source/fp_alu.sv
testbench/fp_alu_properties.sv
testbench/fp_alu_tb.sv

// File: Bender.yml
package:
  name: fp_alu

export_include_dirs:
  - source

sources:
  - files:
      - source/fp_alu_pkg.sv
      - source/fp_logic_unit.sv
      - source/fp_compare_unit.sv
      - source/fp_saturator.sv
      - source/result_delay_line.sv
      - source/fp_alu.sv
  - target: test
    files:
      - testbench/fp_alu_properties.sv
      - testbench/fp_alu_tb.sv

// File: testbench/fp_alu_tb.sv
`timescale 1ns/1ps
`include "fp_alu_consts.svh"

module fp_alu_tb;

    import fp_alu_pkg::*;

    localparam int RESET_CYCLES  = 4;
    localparam int DEPTH         = `FP_ALU_PIPELINE_DEPTH;
    localparam int DRAIN_CYCLES  = DEPTH + 4;
    localparam int SIGN_BIT      = `FP_ALU_DATA_WIDTH - 1;
    localparam word_t MAG_MASK   = {1'b0, {(`FP_ALU_DATA_WIDTH - 1){1'b1}}};

    // Issues per test
    localparam int LOGIC_ISSUES      = 20;
    localparam int COMPARE_ISSUES    = 32;
    localparam int SATURATION_ISSUES = 16;
    localparam int LOAD_ISSUES       = 8;
    localparam int STREAM_ISSUES     = 48;
    localparam int RESET_ISSUES      = 3;
    localparam int TOTAL_ISSUES      = LOGIC_ISSUES + COMPARE_ISSUES + SATURATION_ISSUES
                                     + LOAD_ISSUES + STREAM_ISSUES + RESET_ISSUES;
    localparam int RESET_OBSERVE_CYCLES = 10;

    // Two resets, six burst ends, two drains and the quiet wait after the mid-run reset
    localparam int TIMEOUT_CYCLES = TOTAL_ISSUES + 2 * RESET_CYCLES + 6 + 2 * DRAIN_CYCLES
                                  + RESET_OBSERVE_CYCLES + 20;

    logic      clock;
    logic      reset;
    logic      valid;
    opcode_t   opcode;
    word_t     operand_a;
    word_t     operand_b;
    word_t     constant;
    reg_addr_t dest;
    logic      result_valid;
    word_t     result_data;
    reg_addr_t result_dest;

    word_t     expected_data_q [$];
    reg_addr_t expected_dest_q [$];
    int        expected_cycle_q [$];
    word_t     popped_data;
    reg_addr_t popped_dest;
    int        popped_cycle;
    int        error_count = 0;
    int        check_count = 0;
    int        cycle_count = 0;
    word_t     rand_state = 32'd83;

    fp_alu uut (
        .clock(clock),
        .reset(reset),
        .valid(valid),
        .opcode(opcode),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .constant(constant),
        .dest(dest),
        .result_valid(result_valid),
        .result_data(result_data),
        .result_dest(result_dest)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////

    function automatic word_t xorshift32(input word_t state);
        word_t x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function word_t next_random();
        rand_state = xorshift32(rand_state);
        return rand_state;
    endfunction

    function automatic logic is_zero(input word_t value);
        return (value & MAG_MASK) == '0;
    endfunction

    // Plus and minus zero are the same number
    function automatic logic fp_equal(input word_t a, input word_t b);
        return (a == b) || (is_zero(a) && is_zero(b));
    endfunction

    function automatic logic fp_greater(input word_t a, input word_t b);
        if (fp_equal(a, b)) begin
            return 1'b0;
        end
        if (a[SIGN_BIT] != b[SIGN_BIT]) begin
            if (is_zero(a)) begin
                return b[SIGN_BIT];
            end
            if (is_zero(b)) begin
                return !a[SIGN_BIT];
            end
            return !a[SIGN_BIT];
        end
        // With equal signs a larger magnitude is smaller when negative
        if (!a[SIGN_BIT]) begin
            return (a & MAG_MASK) > (b & MAG_MASK);
        end
        return (a & MAG_MASK) < (b & MAG_MASK);
    endfunction

    // Returns 0 for an opcode that must give no result
    function automatic logic model_result(input opcode_t op, input word_t a, input word_t b,
                                          input word_t const_word, output word_t result);
        model_result = 1'b1;
        result = '0;
        case (op)
            `FP_OP_LAND: result = a & b;
            `FP_OP_LOR:  result = a | b;
            `FP_OP_LXOR: result = a ^ b;
            `FP_OP_LNOT: result = ~a;
            `FP_OP_ABS:  result = a & MAG_MASK;
            `FP_OP_BGT:  result = fp_greater(a, b) ? `FP_CMP_TRUE : '0;
            `FP_OP_BLE:  result = !fp_greater(a, b) ? `FP_CMP_TRUE : '0;
            `FP_OP_BEQ:  result = fp_equal(a, b) ? `FP_CMP_TRUE : '0;
            `FP_OP_BNE:  result = !fp_equal(a, b) ? `FP_CMP_TRUE : '0;
            // b is the upper bound for SATP and the lower bound for SATN
            `FP_OP_SATP: result = fp_greater(a, b) ? b : a;
            `FP_OP_SATN: result = fp_greater(a, b) ? a : b;
            `FP_OP_LDR:  result = a;
            `FP_OP_LDC:  result = const_word;
            default:     model_result = 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////
    // Checks and result monitor
    ////////////////////////////////////////

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic check_dest(input string name, input reg_addr_t actual,
                              input reg_addr_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // Each result matches the oldest expected entry and arrives on its cycle, also in reset
    always @(negedge clock) begin
        if (result_valid === 1'b1) begin
            if (expected_data_q.size() == 0) begin
                error_count++;
                $display("Result at %0t with no issue waiting for it", $time);
            end else begin
                popped_data  = expected_data_q.pop_front();
                popped_dest  = expected_dest_q.pop_front();
                popped_cycle = expected_cycle_q.pop_front();
                check_word("result_data", result_data, popped_data);
                check_dest("result_dest", result_dest, popped_dest);
                if (cycle_count != popped_cycle) begin
                    error_count++;
                    $display("Result came out in cycle %0d instead of cycle %0d",
                             cycle_count, popped_cycle);
                end
            end
        end else if (result_valid === 1'b0) begin
            check_word("result_data", result_data, '0);
            check_dest("result_dest", result_dest, '0);
        end else begin
            error_count++;
            $display("result_valid is unknown at %0t", $time);
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic issue(input opcode_t op, input word_t a, input word_t b,
                         input word_t const_word, input reg_addr_t dst);
        word_t expected;
        @(negedge clock);
        valid     = 1'b1;
        opcode    = op;
        operand_a = a;
        operand_b = b;
        constant  = const_word;
        dest      = dst;
        if (model_result(op, a, b, const_word, expected)) begin
            expected_data_q.push_back(expected);
            expected_dest_q.push_back(dst);
            expected_cycle_q.push_back(cycle_count + DEPTH);
        end
    endtask

    task automatic random_issue(input opcode_t op);
        word_t     a;
        word_t     b;
        word_t     c;
        reg_addr_t d;
        a = next_random();
        b = next_random();
        c = next_random();
        d = reg_addr_t'(next_random());
        issue(op, a, b, c, d);
    endtask

    task automatic end_burst();
        @(negedge clock);
        valid  = 1'b0;
        opcode = '0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (expected_data_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clock);
            waited++;
        end
    endtask

    task automatic test_logic();
        opcode_t ops [5];
        ops = '{`FP_OP_LAND, `FP_OP_LOR, `FP_OP_LXOR, `FP_OP_LNOT, `FP_OP_ABS};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 5; j++) begin
                random_issue(ops[j]);
            end
        end
        end_burst();
    endtask

    task automatic test_compare();
        opcode_t ops [4];
        word_t   pair_a [8];
        word_t   pair_b [8];
        ops = '{`FP_OP_BGT, `FP_OP_BLE, `FP_OP_BEQ, `FP_OP_BNE};
        // Equal, both zero signs, two negatives, mixed signs, then random
        pair_a = '{32'h3F80_0000, 32'h0000_0000, 32'h8000_0000, 32'hBF80_0000,
                   32'hC000_0000, 32'h4020_0000, 32'h0, 32'h0};
        pair_b = '{32'h3F80_0000, 32'h8000_0000, 32'h0000_0000, 32'hC000_0000,
                   32'h3FC0_0000, 32'hBF00_0000, 32'h0, 32'h0};
        for (int p = 6; p < 8; p++) begin
            pair_a[p] = next_random();
            pair_b[p] = next_random();
        end
        for (int p = 0; p < 8; p++) begin
            for (int j = 0; j < 4; j++) begin
                issue(ops[j], pair_a[p], pair_b[p], '0, reg_addr_t'(p * 4 + j));
            end
        end
        end_burst();
    endtask

    task automatic test_saturation();
        word_t value [8];
        word_t bound [8];
        // 3 in 10, 20 over 10, -1 and -8 around -5, -2 against 2, at the bound
        value = '{32'h4040_0000, 32'h41A0_0000, 32'hBF80_0000, 32'hC100_0000,
                  32'hC000_0000, 32'h4120_0000, 32'h0, 32'h0};
        bound = '{32'h4120_0000, 32'h4120_0000, 32'hC0A0_0000, 32'hC0A0_0000,
                  32'h4000_0000, 32'h4120_0000, 32'h0, 32'h0};
        for (int p = 6; p < 8; p++) begin
            value[p] = next_random();
            bound[p] = next_random();
        end
        for (int p = 0; p < 8; p++) begin
            issue(`FP_OP_SATP, value[p], bound[p], '0, reg_addr_t'(8'h80 + p));
            issue(`FP_OP_SATN, value[p], bound[p], '0, reg_addr_t'(8'hC0 + p));
        end
        end_burst();
    endtask

    task automatic test_loads();
        for (int i = 0; i < 4; i++) begin
            random_issue(`FP_OP_LDR);
            random_issue(`FP_OP_LDC);
        end
        end_burst();
    endtask

    // Mixed back-to-back stream with an illegal code after every fifth issue
    task automatic test_stream();
        opcode_t legal [13];
        opcode_t illegal [4];
        legal = '{`FP_OP_LAND, `FP_OP_LOR, `FP_OP_LXOR, `FP_OP_LNOT, `FP_OP_ABS,
                  `FP_OP_BGT, `FP_OP_BLE, `FP_OP_BEQ, `FP_OP_BNE,
                  `FP_OP_SATP, `FP_OP_SATN, `FP_OP_LDR, `FP_OP_LDC};
        illegal = '{8'h00, 8'h15, 8'h32, 8'hFF};
        for (int i = 0; i < 40; i++) begin
            random_issue(legal[int'(next_random() % 13)]);
            if (i % 5 == 4) begin
                random_issue(illegal[int'(next_random() % 4)]);
            end
        end
        end_burst();
    endtask

    task automatic test_reset_in_flight();
        wait_for_drain();
        random_issue(`FP_OP_LDR);
        random_issue(`FP_OP_LAND);
        random_issue(`FP_OP_SATP);
        // Reset lands before any of the three can come out
        @(negedge clock);
        valid = 1'b0;
        reset = 1'b1;
        expected_data_q.delete();
        expected_dest_q.delete();
        expected_cycle_q.delete();
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        repeat (RESET_OBSERVE_CYCLES) @(negedge clock);
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        valid     = 1'b0;
        opcode    = '0;
        operand_a = '0;
        operand_b = '0;
        constant  = '0;
        dest      = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        test_logic();
        test_compare();
        test_saturation();
        test_loads();
        test_stream();
        test_reset_in_flight();

        wait_for_drain();
        repeat (2) @(negedge clock);
        if (expected_data_q.size() != 0) begin
            error_count++;
            $display("%0d expected results never came out of the DUT", expected_data_q.size());
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: testbench/fp_alu_properties.sv
`timescale 1ns/1ps
`include "fp_alu_consts.svh"

module fp_alu_properties (
    input logic                clock,
    input logic                reset,
    input logic                valid,
    input fp_alu_pkg::opcode_t opcode,
    input logic                result_valid
);

    import fp_alu_pkg::*;

    function automatic logic legal_opcode(input opcode_t code);
        case (code)
            `FP_OP_LAND, `FP_OP_LOR, `FP_OP_LXOR, `FP_OP_LNOT, `FP_OP_ABS,
            `FP_OP_BGT, `FP_OP_BLE, `FP_OP_BEQ, `FP_OP_BNE,
            `FP_OP_SATP, `FP_OP_SATN, `FP_OP_LDR, `FP_OP_LDC: legal_opcode = 1'b1;
            default: legal_opcode = 1'b0;
        endcase
    endfunction

    // First reset edge clears every stage
    property quiet_in_reset;
        @(posedge clock) reset |=> !result_valid;
    endproperty

    property result_after_legal_issue;
        @(posedge clock) disable iff (reset)
        valid && legal_opcode(opcode) |-> ##(`FP_ALU_PIPELINE_DEPTH) result_valid;
    endproperty

    property nothing_after_illegal_issue;
        @(posedge clock) disable iff (reset)
        valid && !legal_opcode(opcode) |-> ##(`FP_ALU_PIPELINE_DEPTH) !result_valid;
    endproperty

    assert property (quiet_in_reset)
        else $error("result_valid high after reset was applied");
    assert property (result_after_legal_issue)
        else $error("legal issue gave no result at the pipeline depth");
    assert property (nothing_after_illegal_issue)
        else $error("illegal issue produced a result");

endmodule

bind fp_alu fp_alu_properties timing_properties (
    .clock(clock),
    .reset(reset),
    .valid(valid),
    .opcode(opcode),
    .result_valid(result_valid)
);

// File: source/fp_alu.sv
`timescale 1ns/1ps
`include "fp_alu_consts.svh"

module fp_alu (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  valid,
    input  fp_alu_pkg::opcode_t   opcode,
    input  fp_alu_pkg::word_t     operand_a,
    input  fp_alu_pkg::word_t     operand_b,
    input  fp_alu_pkg::word_t     constant,
    input  fp_alu_pkg::reg_addr_t dest,
    output logic                  result_valid,
    output fp_alu_pkg::word_t     result_data,
    output fp_alu_pkg::reg_addr_t result_dest
);

    import fp_alu_pkg::*;

    // Internal latency of each lane
    localparam int LOGIC_LATENCY      = 1;
    localparam int COMPARE_LATENCY    = 1;
    localparam int SATURATION_LATENCY = 2;
    localparam int LOAD_LATENCY       = 0;

    // Lane outputs
    logic      logic_valid;
    word_t     logic_data;
    reg_addr_t logic_dest;
    logic      compare_valid;
    word_t     compare_data;
    reg_addr_t compare_dest;
    logic      saturation_valid;
    word_t     saturation_data;
    reg_addr_t saturation_dest;
    logic      load_valid;
    word_t     load_data;

    // Lane outputs aligned to the full depth
    logic      logic_aligned_valid;
    word_t     logic_aligned_data;
    reg_addr_t logic_aligned_dest;
    logic      compare_aligned_valid;
    word_t     compare_aligned_data;
    reg_addr_t compare_aligned_dest;
    logic      saturation_aligned_valid;
    word_t     saturation_aligned_data;
    reg_addr_t saturation_aligned_dest;
    logic      load_aligned_valid;
    word_t     load_aligned_data;
    reg_addr_t load_aligned_dest;

    ////////////////////////////////////////
    // Functional lanes
    ////////////////////////////////////////

    fp_logic_unit logic_unit (
        .clock(clock),
        .reset(reset),
        .in_valid(valid),
        .opcode(opcode),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .dest(dest),
        .out_valid(logic_valid),
        .out_data(logic_data),
        .out_dest(logic_dest)
    );

    fp_compare_unit compare_unit (
        .clock(clock),
        .reset(reset),
        .in_valid(valid),
        .opcode(opcode),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .dest(dest),
        .out_valid(compare_valid),
        .out_data(compare_data),
        .out_dest(compare_dest)
    );

    fp_saturator saturator (
        .clock(clock),
        .reset(reset),
        .in_valid(valid),
        .opcode(opcode),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .dest(dest),
        .out_valid(saturation_valid),
        .out_data(saturation_data),
        .out_dest(saturation_dest)
    );

    // Load lane, LDC takes the constant word
    assign load_valid = valid && ((opcode == `FP_OP_LDR) || (opcode == `FP_OP_LDC));
    assign load_data  = (opcode == `FP_OP_LDC) ? constant : operand_a;

    ////////////////////////////////////////
    // Alignment to the pipeline depth
    ////////////////////////////////////////

    result_delay_line #(
        .STAGES(`FP_ALU_PIPELINE_DEPTH - LOGIC_LATENCY)
    ) logic_delay (
        .clock(clock),
        .reset(reset),
        .in_valid(logic_valid),
        .in_data(logic_data),
        .in_dest(logic_dest),
        .out_valid(logic_aligned_valid),
        .out_data(logic_aligned_data),
        .out_dest(logic_aligned_dest)
    );

    result_delay_line #(
        .STAGES(`FP_ALU_PIPELINE_DEPTH - COMPARE_LATENCY)
    ) compare_delay (
        .clock(clock),
        .reset(reset),
        .in_valid(compare_valid),
        .in_data(compare_data),
        .in_dest(compare_dest),
        .out_valid(compare_aligned_valid),
        .out_data(compare_aligned_data),
        .out_dest(compare_aligned_dest)
    );

    result_delay_line #(
        .STAGES(`FP_ALU_PIPELINE_DEPTH - SATURATION_LATENCY)
    ) saturation_delay (
        .clock(clock),
        .reset(reset),
        .in_valid(saturation_valid),
        .in_data(saturation_data),
        .in_dest(saturation_dest),
        .out_valid(saturation_aligned_valid),
        .out_data(saturation_aligned_data),
        .out_dest(saturation_aligned_dest)
    );

    result_delay_line #(
        .STAGES(`FP_ALU_PIPELINE_DEPTH - LOAD_LATENCY)
    ) load_delay (
        .clock(clock),
        .reset(reset),
        .in_valid(load_valid),
        .in_data(load_data),
        .in_dest(dest),
        .out_valid(load_aligned_valid),
        .out_data(load_aligned_data),
        .out_dest(load_aligned_dest)
    );

    ////////////////////////////////////////
    // Result selection
    ////////////////////////////////////////

    // Equal lane depths leave at most one valid high per cycle
    always_comb begin
        result_valid = 1'b0;
        result_data  = '0;
        result_dest  = '0;
        if (logic_aligned_valid) begin
            result_valid = 1'b1;
            result_data  = logic_aligned_data;
            result_dest  = logic_aligned_dest;
        end else if (compare_aligned_valid) begin
            result_valid = 1'b1;
            result_data  = compare_aligned_data;
            result_dest  = compare_aligned_dest;
        end else if (saturation_aligned_valid) begin
            result_valid = 1'b1;
            result_data  = saturation_aligned_data;
            result_dest  = saturation_aligned_dest;
        end else if (load_aligned_valid) begin
            result_valid = 1'b1;
            result_data  = load_aligned_data;
            result_dest  = load_aligned_dest;
        end
    end

endmodule

// File: source/result_delay_line.sv
`timescale 1ns/1ps

module result_delay_line #(
    parameter int STAGES = 1
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  fp_alu_pkg::word_t     in_data,
    input  fp_alu_pkg::reg_addr_t in_dest,
    output logic                  out_valid,
    output fp_alu_pkg::word_t     out_data,
    output fp_alu_pkg::reg_addr_t out_dest
);

    import fp_alu_pkg::*;

    logic      valid_stage [STAGES];
    word_t     data_stage  [STAGES];
    reg_addr_t dest_stage  [STAGES];

    // Plain shift register, one entry per cycle of delay
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < STAGES; i++) begin
                valid_stage[i] <= 1'b0;
                data_stage[i]  <= '0;
                dest_stage[i]  <= '0;
            end
        end else begin
            valid_stage[0] <= in_valid;
            data_stage[0]  <= in_data;
            dest_stage[0]  <= in_dest;
            for (int i = 1; i < STAGES; i++) begin
                valid_stage[i] <= valid_stage[i-1];
                data_stage[i]  <= data_stage[i-1];
                dest_stage[i]  <= dest_stage[i-1];
            end
        end
    end

    assign out_valid = valid_stage[STAGES-1];
    assign out_data  = data_stage[STAGES-1];
    assign out_dest  = dest_stage[STAGES-1];

endmodule

// File: source/fp_saturator.sv
`timescale 1ns/1ps
`include "fp_alu_consts.svh"

module fp_saturator (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  fp_alu_pkg::opcode_t   opcode,
    input  fp_alu_pkg::word_t     operand_a,
    input  fp_alu_pkg::word_t     operand_b,
    input  fp_alu_pkg::reg_addr_t dest,
    output logic                  out_valid,
    output fp_alu_pkg::word_t     out_data,
    output fp_alu_pkg::reg_addr_t out_dest
);

    import fp_alu_pkg::*;

    logic      is_saturation_op;

    // Stage 1 state
    logic      stage1_valid;
    logic      stage1_upper;
    logic      stage1_a_greater;
    word_t     stage1_a;
    word_t     stage1_b;
    reg_addr_t stage1_dest;

    word_t     clamped_value;

    assign is_saturation_op = (opcode == `FP_OP_SATP) || (opcode == `FP_OP_SATN);

    ////////////////////////////////////////
    // Stage 1, operand ordering
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            stage1_valid     <= 1'b0;
            stage1_upper     <= 1'b0;
            stage1_a_greater <= 1'b0;
            stage1_a         <= '0;
            stage1_b         <= '0;
            stage1_dest      <= '0;
        end else begin
            stage1_valid     <= in_valid && is_saturation_op;
            stage1_upper     <= opcode == `FP_OP_SATP;
            stage1_a_greater <= fp_order_key(operand_a) > fp_order_key(operand_b);
            stage1_a         <= operand_a;
            stage1_b         <= operand_b;
            stage1_dest      <= dest;
        end
    end

    ////////////////////////////////////////
    // Stage 2, bound selection
    ////////////////////////////////////////

    // SATP keeps the smaller value, SATN the larger
    assign clamped_value = (stage1_upper == stage1_a_greater) ? stage1_b : stage1_a;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            out_dest  <= '0;
        end else begin
            out_valid <= stage1_valid;
            out_data  <= clamped_value;
            out_dest  <= stage1_dest;
        end
    end

endmodule

// File: source/fp_compare_unit.sv
`timescale 1ns/1ps
`include "fp_alu_consts.svh"

module fp_compare_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  fp_alu_pkg::opcode_t   opcode,
    input  fp_alu_pkg::word_t     operand_a,
    input  fp_alu_pkg::word_t     operand_b,
    input  fp_alu_pkg::reg_addr_t dest,
    output logic                  out_valid,
    output fp_alu_pkg::word_t     out_data,
    output fp_alu_pkg::reg_addr_t out_dest
);

    import fp_alu_pkg::*;

    order_key_t key_a;
    order_key_t key_b;
    logic       condition;
    logic       is_compare_op;

    assign key_a = fp_order_key(operand_a);
    assign key_b = fp_order_key(operand_b);

    // Branch condition for the four compare opcodes
    always_comb begin
        is_compare_op = 1'b1;
        condition     = 1'b0;
        case (opcode)
            `FP_OP_BGT: condition = key_a > key_b;
            `FP_OP_BLE: condition = key_a <= key_b;
            `FP_OP_BEQ: condition = key_a == key_b;
            `FP_OP_BNE: condition = key_a != key_b;
            default:    is_compare_op = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            out_dest  <= '0;
        end else begin
            out_valid <= in_valid && is_compare_op;
            // All ones for taken, zero otherwise
            out_data  <= condition ? `FP_CMP_TRUE : '0;
            out_dest  <= dest;
        end
    end

endmodule

// File: source/fp_logic_unit.sv
`timescale 1ns/1ps
`include "fp_alu_consts.svh"

module fp_logic_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  fp_alu_pkg::opcode_t   opcode,
    input  fp_alu_pkg::word_t     operand_a,
    input  fp_alu_pkg::word_t     operand_b,
    input  fp_alu_pkg::reg_addr_t dest,
    output logic                  out_valid,
    output fp_alu_pkg::word_t     out_data,
    output fp_alu_pkg::reg_addr_t out_dest
);

    import fp_alu_pkg::*;

    word_t logic_value;
    logic  is_logic_op;

    ////////////////////////////////////////
    // Bitwise operation decode
    ////////////////////////////////////////

    always_comb begin
        is_logic_op = 1'b1;
        logic_value = '0;
        case (opcode)
            `FP_OP_LAND: begin
                logic_value = operand_a & operand_b;
            end
            `FP_OP_LOR: begin
                logic_value = operand_a | operand_b;
            end
            `FP_OP_LXOR: begin
                logic_value = operand_a ^ operand_b;
            end
            `FP_OP_LNOT: begin
                logic_value = ~operand_a;
            end
            `FP_OP_ABS: begin
                // Only the sign bit is dropped
                logic_value = {1'b0, operand_a[`FP_ALU_DATA_WIDTH-2:0]};
            end
            default: begin
                is_logic_op = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // Result register
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            out_dest  <= '0;
        end else begin
            out_valid <= in_valid && is_logic_op;
            out_data  <= logic_value;
            out_dest  <= dest;
        end
    end

endmodule

// File: source/fp_alu_pkg.sv
`include "fp_alu_consts.svh"

package fp_alu_pkg;

    // Single precision float or raw data word
    typedef logic [`FP_ALU_DATA_WIDTH-1:0] word_t;

    // Destination register address
    typedef logic [`FP_ALU_REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [`FP_ALU_OPCODE_WIDTH-1:0] opcode_t;

    // Signed key that orders floats by sign and magnitude
    typedef logic signed [`FP_ALU_DATA_WIDTH-1:0] order_key_t;

    // Shared by the compare and saturation lanes
    function automatic order_key_t fp_order_key(input word_t value);
        order_key_t magnitude;
        magnitude = {1'b0, value[`FP_ALU_DATA_WIDTH-2:0]};
        // +0 and -0 both map to key 0
        if (value[`FP_ALU_DATA_WIDTH-1]) begin
            fp_order_key = -magnitude;
        end else begin
            fp_order_key = magnitude;
        end
    endfunction

endpackage

// File: source/fp_alu_consts.svh
`ifndef FP_ALU_CONSTS_SVH
`define FP_ALU_CONSTS_SVH

// Datapath and register file sizes
`define FP_ALU_DATA_WIDTH 32
`define FP_ALU_REG_ADDR_WIDTH 8
`define FP_ALU_OPCODE_WIDTH 8

// Cycles from issue to result, same for every lane
`define FP_ALU_PIPELINE_DEPTH 5

// Opcode encodings
`define FP_OP_LAND 8'h10
`define FP_OP_LOR 8'h11
`define FP_OP_LXOR 8'h12
`define FP_OP_LNOT 8'h13
`define FP_OP_ABS 8'h14
`define FP_OP_BGT 8'h20
`define FP_OP_BLE 8'h21
`define FP_OP_BEQ 8'h22
`define FP_OP_BNE 8'h23
`define FP_OP_SATP 8'h30
`define FP_OP_SATN 8'h31
`define FP_OP_LDR 8'h40
`define FP_OP_LDC 8'h41

// Word returned by a true compare, a false one returns zero
`define FP_CMP_TRUE {`FP_ALU_DATA_WIDTH{1'b1}}

`endif
